// File: files.f
src/common_pkg.sv
src/cpu_bus_timing.sv
src/bus_arbiter.sv
src/video_fetch.sv
src/host_port.sv
src/bus_ram.sv
src/pet_bus_top.sv
dv/tb_pet_bus.sv

// File: Makefile
# Verilator build and run of the shared-memory bus testbench

VERILATOR ?= verilator
TOP       ?= tb_pet_bus
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_pet_bus.sv
// Shared-memory bus testbench checking host, CPU and video traffic against a shadow RAM
`timescale 1ns/10ps

module tb_pet_bus;
    import common_pkg::*;

    // Worst-case bounds per RAM access and per CPU cycle
    localparam int ACCESS_CYCLES  = 40;
    localparam int CPU_CYCLES     = 16;
    localparam int HOST_ACCESSES  = 64 + 4 + VIDEO_CHARS + 48;  // Round trip, readback, fill, contention
    localparam int VIDEO_ACCESSES = VIDEO_CHARS + 2 + 48;
    localparam int CPU_ACCESSES   = 6 + 12 + 8;                 // Waveform, CPU access, contention
    localparam int TIMEOUT_CYCLES = 24 + (HOST_ACCESSES + VIDEO_ACCESSES) * ACCESS_CYCLES
                                  + CPU_ACCESSES * CPU_CYCLES + 2000;

    logic        sys_clock = 1'b0;
    logic        reset;
    logic        cpu_run;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_wdata;
    logic        cpu_rwb;
    logic        char_req;
    logic        host_start;
    logic        host_we;
    logic [15:0] host_addr;
    logic [7:0]  host_wdata;
    logic        cpu_be;
    logic        cpu_clock;
    logic        cpu_strobe;
    logic [7:0]  cpu_rdata;
    logic [7:0]  video_data;
    logic        video_valid;
    logic [7:0]  host_rdata;
    logic        host_done;

    logic [7:0]  shadow [0:65535];      // Expected RAM contents
    logic [15:0] addr_list [0:31];      // Addresses preloaded by the host
    logic [31:0] lcg_state = 32'hb6f9;
    int unsigned cyc = 0;
    int          errors = 0;
    int          checks = 0;
    int          vid_off = 0;           // Expected fetch offset

    // CPU waveform monitor state
    logic        wave_chk = 1'b0;       // Strobe period checked while set
    logic        have_strobe = 1'b0;
    logic        prev_clk = 1'b0;
    int unsigned last_strobe = 0;
    int          strobe_count = 0;
    int          clk_high = 0;
    int          be_high = 0;

    always #10 sys_clock = ~sys_clock;  // 20 ns period

    pet_bus_top UUT (
        .sys_clock_i   (sys_clock),
        .reset_i       (reset),
        .cpu_run_i     (cpu_run),
        .cpu_addr_i    (cpu_addr),
        .cpu_data_i    (cpu_wdata),
        .cpu_rwb_i     (cpu_rwb),
        .cpu_be_o      (cpu_be),
        .cpu_clock_o   (cpu_clock),
        .cpu_strobe_o  (cpu_strobe),
        .cpu_data_o    (cpu_rdata),
        .char_req_i    (char_req),
        .video_data_o  (video_data),
        .video_valid_o (video_valid),
        .host_start_i  (host_start),
        .host_we_i     (host_we),
        .host_addr_i   (host_addr),
        .host_wdata_i  (host_wdata),
        .host_rdata_o  (host_rdata),
        .host_done_o   (host_done)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    // Cycle limit so a stuck handshake cannot hang the run
    always @(posedge sys_clock) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("timeout: no DUT response within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // Phi2 and BE widths plus strobe alignment and period sampled mid-cycle
    always @(negedge sys_clock) begin
        if (!reset) begin
            if (cpu_clock) begin
                clk_high++;
            end else if (clk_high != 0) begin
                check("phi2_high_width", 32'(CPU_PHI_END - CPU_PHI_START), 32'(clk_high));
                clk_high = 0;
            end
            if (cpu_be) begin
                be_high++;
            end else if (be_high != 0) begin
                check("be_high_width", 32'(CPU_BE_END - CPU_BE_START), 32'(be_high));
                be_high = 0;
            end
            if (cpu_strobe) begin
                check("strobe_on_phi2_rise", 32'd1, 32'(cpu_clock && !prev_clk));
                if (wave_chk && have_strobe) begin
                    check("strobe_period", 32'(CPU_CYCLES), cyc - last_strobe);
                end
                have_strobe = wave_chk;
                last_strobe = cyc;
                strobe_count++;
            end
            if (!wave_chk) have_strobe = 1'b0;  // Gap after a stop is not a period
            prev_clk = cpu_clock;
        end
    end

    // One host access from start to done with the shadow updated on writes
    task automatic host_xfer(input logic we, input logic [15:0] addr, input logic [7:0] wdata,
                             output logic [7:0] rdata);
        host_start = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = wdata;
        @(negedge sys_clock);
        host_start = 1'b0;
        while (!host_done) @(negedge sys_clock);
        rdata = host_rdata;
        if (we) shadow[addr] = wdata;
    endtask

    task automatic host_read_check(input string name, input logic [15:0] addr);
        logic [7:0] rd;
        host_xfer(1'b0, addr, 8'h00, rd);
        check(name, 32'(shadow[addr]), 32'(rd));
    endtask

    task automatic fetch_char_check(input string name);
        logic [15:0] addr;
        char_req = 1'b1;
        @(negedge sys_clock);
        char_req = 1'b0;
        while (!video_valid) @(negedge sys_clock);
        addr = VIDEO_BASE + 16'(vid_off);
        check(name, 32'(shadow[addr]), 32'(video_data));
        vid_off = (vid_off == VIDEO_CHARS - 1) ? 0 : vid_off + 1;  // Screen wrap
    endtask

    // Acts as the CPU for one bus cycle and checks a read at Phi2 fall
    task automatic cpu_cycle(input string name, input logic rwb, input logic [15:0] addr,
                             input logic [7:0] data);
        cpu_rwb   = rwb;
        cpu_addr  = addr;
        cpu_wdata = data;
        do @(negedge sys_clock); while (!cpu_strobe);
        do @(negedge sys_clock); while (cpu_clock);
        if (rwb) check(name, 32'(shadow[addr]), 32'(cpu_rdata));
        else shadow[addr] = data;
        cpu_rwb = 1'b1;                 // Park as a harmless read
    endtask

    // Grant lags the run level by one clock, so a new cycle may still start
    task automatic stop_cpu();
        cpu_run = 1'b0;
        repeat (2) @(negedge sys_clock);
        while (cpu_be) @(negedge sys_clock);
    endtask

    task automatic reset_state_test();
        repeat (20) begin
            @(negedge sys_clock);
            check("reset_state", 32'd0, 32'({cpu_be, cpu_clock, host_done, video_valid}));
        end
    endtask

    task automatic host_round_trip_test();
        logic [31:0] r;
        logic [7:0]  rd;
        for (int i = 0; i < 32; i++) begin
            r = next_random();
            addr_list[i] = r[15:0];
            host_xfer(1'b1, r[15:0], r[23:16], rd);
        end
        for (int i = 0; i < 32; i++) host_read_check("host_round_trip", addr_list[i]);
    endtask

    task automatic cpu_waveform_test();
        int first;
        first = strobe_count;
        cpu_run  = 1'b1;
        wave_chk = 1'b1;
        while (strobe_count < first + 5) @(negedge sys_clock);
        wave_chk = 1'b0;
        stop_cpu();                     // Current cycle runs to its end
        first = strobe_count;
        repeat (2 * CPU_CYCLES) begin
            @(negedge sys_clock);
            check("cpu_stopped", 32'd0, 32'(cpu_be));
        end
        check("cpu_stopped_strobes", first, strobe_count);
    endtask

    task automatic cpu_access_test();
        logic [31:0] r;
        logic [15:0] wr_addr [0:3];
        cpu_run = 1'b1;
        for (int i = 0; i < 4; i++) begin
            r = next_random();
            wr_addr[i] = r[15:0];
            cpu_cycle("cpu_write", 1'b0, r[15:0], r[23:16]);
        end
        for (int i = 0; i < 4; i++) host_read_check("cpu_write_readback", wr_addr[i]);
        for (int i = 0; i < 8; i++) cpu_cycle("cpu_read", 1'b1, addr_list[i], 8'h00);
        stop_cpu();
    endtask

    task automatic video_stream_test();
        logic [31:0] r;
        logic [7:0]  rd;
        for (int i = 0; i < VIDEO_CHARS; i++) begin
            r = next_random();
            host_xfer(1'b1, VIDEO_BASE + 16'(i), r[31:24], rd);
        end
        // Two past the end so offsets 0 and 1 come round again
        for (int i = 0; i < VIDEO_CHARS + 2; i++) fetch_char_check("video_stream");
    endtask

    // Host stays below screen memory so the screen reads have fixed expectations
    task automatic contention_test();
        cpu_rwb  = 1'b1;
        cpu_addr = VIDEO_BASE;
        cpu_run  = 1'b1;
        wave_chk = 1'b1;
        fork
            begin
                logic [31:0] r;
                logic [7:0]  rd;
                for (int i = 0; i < 24; i++) begin
                    r = next_random();
                    host_xfer(1'b1, {1'b0, r[14:0]}, r[23:16], rd);
                    host_read_check("contention_host", {1'b0, r[14:0]});
                end
            end
            begin
                for (int i = 0; i < 48; i++) fetch_char_check("contention_video");
            end
            begin
                for (int i = 0; i < 8; i++) begin
                    cpu_cycle("contention_cpu", 1'b1, VIDEO_BASE + 16'(i * 97), 8'h00);
                end
            end
        join
        wave_chk = 1'b0;
        stop_cpu();
    endtask

    initial begin
        reset      = 1'b1;
        cpu_run    = 1'b0;
        cpu_addr   = 16'h0000;
        cpu_wdata  = 8'h00;
        cpu_rwb    = 1'b1;
        char_req   = 1'b0;
        host_start = 1'b0;
        host_we    = 1'b0;
        host_addr  = 16'h0000;
        host_wdata = 8'h00;
        repeat (4) @(negedge sys_clock);
        reset = 1'b0;
        reset_state_test();
        host_round_trip_test();
        cpu_waveform_test();
        cpu_access_test();
        video_stream_test();
        contention_test();
        $display("tb_pet_bus: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: src/pet_bus_top.sv
// Shared-memory bus top: CPU, video and host requesters sharing one RAM through the arbiter
`timescale 1ns/10ps

module pet_bus_top (
    input  logic        sys_clock_i,
    input  logic        reset_i,
    input  logic        cpu_run_i,
    // CPU pins
    input  logic [15:0] cpu_addr_i,
    input  logic [7:0]  cpu_data_i,
    input  logic        cpu_rwb_i,
    output logic        cpu_be_o,
    output logic        cpu_clock_o,
    output logic        cpu_strobe_o,
    output logic [7:0]  cpu_data_o,
    // Character fetch
    input  logic        char_req_i,
    output logic [7:0]  video_data_o,
    output logic        video_valid_o,
    // Host access
    input  logic        host_start_i,
    input  logic        host_we_i,
    input  logic [15:0] host_addr_i,
    input  logic [7:0]  host_wdata_i,
    output logic [7:0]  host_rdata_o,
    output logic        host_done_o
);
    import common_pkg::*;

    bus_req_t   cpu_req, video_req, host_req;
    bus_req_t   ram_req;                        // Winner's access
    logic       cpu_ack, video_ack, host_ack;
    logic       cpu_grant;
    logic [7:0] rdata;                          // Shared read return

    cpu_bus_timing u_cpu (
        .sys_clock_i  (sys_clock_i),
        .reset_i      (reset_i),
        .cpu_grant_i  (cpu_grant),
        .cpu_addr_i   (cpu_addr_i),
        .cpu_data_i   (cpu_data_i),
        .cpu_rwb_i    (cpu_rwb_i),
        .cpu_ack_i    (cpu_ack),
        .bus_rdata_i  (rdata),
        .cpu_be_o     (cpu_be_o),
        .cpu_clock_o  (cpu_clock_o),
        .cpu_strobe_o (cpu_strobe_o),
        .cpu_data_o   (cpu_data_o),
        .cpu_req_o    (cpu_req)
    );

    video_fetch u_video (
        .sys_clock_i   (sys_clock_i),
        .reset_i       (reset_i),
        .char_req_i    (char_req_i),
        .video_ack_i   (video_ack),
        .bus_rdata_i   (rdata),
        .video_req_o   (video_req),
        .video_data_o  (video_data_o),
        .video_valid_o (video_valid_o)
    );

    host_port u_host (
        .sys_clock_i  (sys_clock_i),
        .reset_i      (reset_i),
        .host_start_i (host_start_i),
        .host_we_i    (host_we_i),
        .host_addr_i  (host_addr_i),
        .host_wdata_i (host_wdata_i),
        .host_ack_i   (host_ack),
        .bus_rdata_i  (rdata),
        .host_req_o   (host_req),
        .host_rdata_o (host_rdata_o),
        .host_done_o  (host_done_o)
    );

    bus_arbiter u_arb (
        .sys_clock_i (sys_clock_i),
        .reset_i     (reset_i),
        .cpu_run_i   (cpu_run_i),
        .cpu_req_i   (cpu_req),
        .video_req_i (video_req),
        .host_req_i  (host_req),
        .cpu_grant_o (cpu_grant),
        .cpu_ack_o   (cpu_ack),
        .video_ack_o (video_ack),
        .host_ack_o  (host_ack),
        .ram_req_o   (ram_req)
    );

    bus_ram u_ram (
        .sys_clock_i (sys_clock_i),
        .ram_req_i   (ram_req),
        .ram_rdata_o (rdata)
    );

endmodule

// File: src/bus_ram.sv
// Single-port byte RAM with a registered read port, one cycle of read latency
`timescale 1ns/10ps

module bus_ram (
    input  logic                 sys_clock_i,
    input  common_pkg::bus_req_t ram_req_i,
    output logic [7:0]           ram_rdata_o
);
    import common_pkg::*;

    logic [7:0] mem [0:(2**RAM_ADDR_BITS)-1];

    // Every access also reads, so a write returns the old byte
    always_ff @(posedge sys_clock_i) begin
        if (ram_req_i.valid) begin
            if (ram_req_i.we) begin
                mem[ram_req_i.addr] <= ram_req_i.wdata;
            end
            ram_rdata_o <= mem[ram_req_i.addr];     // Read-first
        end
    end

endmodule

// File: src/host_port.sv
// Host access port: turns a start pulse into a held RAM request and returns data with done
`timescale 1ns/10ps

module host_port (
    input  logic                 sys_clock_i,
    input  logic                 reset_i,
    input  logic                 host_start_i,
    input  logic                 host_we_i,
    input  logic [15:0]          host_addr_i,
    input  logic [7:0]           host_wdata_i,
    input  logic                 host_ack_i,
    input  logic [7:0]           bus_rdata_i,
    output common_pkg::bus_req_t host_req_o,
    output logic [7:0]           host_rdata_o,
    output logic                 host_done_o
);
    logic        busy_q;
    logic        we_q;                  // Latched command
    logic [15:0] addr_q;
    logic [7:0]  wdata_q;
    logic [7:0]  rdata_q;               // Held result after done

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            busy_q      <= 1'b0;
            host_done_o <= 1'b0;
        end else begin
            host_done_o <= host_ack_i;
            if (host_ack_i) begin
                busy_q <= 1'b0;
            end else if (host_start_i && !busy_q) begin
                busy_q <= 1'b1;         // A start while busy is ignored
            end
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (host_start_i && !busy_q) begin
            we_q    <= host_we_i;
            addr_q  <= host_addr_i;
            wdata_q <= host_wdata_i;
        end
        if (host_done_o) begin
            rdata_q <= bus_rdata_i;
        end
    end

    assign host_req_o = '{valid: busy_q, we: we_q, addr: addr_q, wdata: wdata_q};

    // Read data is on the bus during the done cycle
    assign host_rdata_o = host_done_o ? bus_rdata_i : rdata_q;

endmodule

// File: src/video_fetch.sv
// Character fetcher: reads screen memory in order, one byte per request, wrapping at screen end
`timescale 1ns/10ps

module video_fetch (
    input  logic                 sys_clock_i,
    input  logic                 reset_i,
    input  logic                 char_req_i,
    input  logic                 video_ack_i,
    input  logic [7:0]           bus_rdata_i,
    output common_pkg::bus_req_t video_req_o,
    output logic [7:0]           video_data_o,
    output logic                 video_valid_o
);
    import common_pkg::*;

    logic                         busy_q;       // Read waiting for the arbiter
    logic [VIDEO_OFFSET_BITS-1:0] offset_q;     // Position within the screen
    logic [7:0]                   char_q;       // Last character fetched

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            busy_q        <= 1'b0;
            offset_q      <= '0;
            video_valid_o <= 1'b0;
        end else begin
            video_valid_o <= video_ack_i;       // Data lands one cycle after ack
            if (video_ack_i) begin
                busy_q <= 1'b0;
                if (offset_q == VIDEO_OFFSET_BITS'(VIDEO_CHARS - 1)) begin
                    offset_q <= '0;             // Back to top of screen
                end else begin
                    offset_q <= offset_q + 1'b1;
                end
            end else if (char_req_i && !busy_q) begin
                busy_q <= 1'b1;                 // Requests while busy are dropped
            end
        end
    end

    // Read only, the address follows the running offset
    always_comb begin
        video_req_o.valid = busy_q;
        video_req_o.we    = 1'b0;
        video_req_o.addr  = VIDEO_BASE + RAM_ADDR_BITS'(offset_q);
        video_req_o.wdata = '0;
    end

    always_ff @(posedge sys_clock_i) begin
        if (video_valid_o) begin
            char_q <= bus_rdata_i;
        end
    end

    // Pass RAM data through on the valid cycle, then hold it
    assign video_data_o = video_valid_o ? bus_rdata_i : char_q;

endmodule

// File: src/bus_arbiter.sv
// Fixed-priority RAM arbiter: one access per cycle, CPU first, then video, then host
`timescale 1ns/10ps

module bus_arbiter (
    input  logic                 sys_clock_i,
    input  logic                 reset_i,
    input  logic                 cpu_run_i,
    input  common_pkg::bus_req_t cpu_req_i,
    input  common_pkg::bus_req_t video_req_i,
    input  common_pkg::bus_req_t host_req_i,
    output logic                 cpu_grant_o,
    output logic                 cpu_ack_o,
    output logic                 video_ack_o,
    output logic                 host_ack_o,
    output common_pkg::bus_req_t ram_req_o
);
    import common_pkg::*;

    bus_src_e owner;

    // Priority select.
    // The CPU strobe always wins so its timing is fixed
    always_comb begin
        if (cpu_req_i.valid) begin
            owner = SRC_CPU;
        end else if (video_req_i.valid) begin
            owner = SRC_VIDEO;          // Screen fetch beats host traffic
        end else if (host_req_i.valid) begin
            owner = SRC_HOST;
        end else begin
            owner = SRC_NONE;
        end
    end

    // Forward the winner's request straight to the RAM port
    always_comb begin
        case (owner)
            SRC_CPU:   ram_req_o = cpu_req_i;
            SRC_VIDEO: ram_req_o = video_req_i;
            SRC_HOST:  ram_req_o = host_req_i;
            default:   ram_req_o = '0;  // Idle, valid low
        endcase
    end

    // Ack is the same cycle the access hits the RAM
    assign cpu_ack_o   = (owner == SRC_CPU);
    assign video_ack_o = (owner == SRC_VIDEO);
    assign host_ack_o  = (owner == SRC_HOST);

    // Run level registered as the CPU grant
    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            cpu_grant_o <= 1'b0;
        end else begin
            cpu_grant_o <= cpu_run_i;
        end
    end

    a_ack_onehot0 : assert property (
        @(posedge sys_clock_i) disable iff (reset_i)
        $onehot0({cpu_ack_o, video_ack_o, host_ack_o})
    );

    // Requesters must drop valid right after being served,
    // otherwise the same access would be issued twice
    a_cpu_drops : assert property (
        @(posedge sys_clock_i) disable iff (reset_i)
        cpu_ack_o |=> !cpu_req_i.valid
    );

    a_video_drops : assert property (
        @(posedge sys_clock_i) disable iff (reset_i)
        video_ack_o |=> !video_req_i.valid
    );

    a_host_drops : assert property (
        @(posedge sys_clock_i) disable iff (reset_i)
        host_ack_o |=> !host_req_i.valid
    );

endmodule

// File: src/cpu_bus_timing.sv
// CPU bus timing: derives BE, Phi2 and the transfer strobe and bridges CPU pins to the bus
`timescale 1ns/10ps

module cpu_bus_timing (
    input  logic                sys_clock_i,
    input  logic                reset_i,
    input  logic                cpu_grant_i,    // Registered run level from the arbiter
    input  logic [15:0]         cpu_addr_i,
    input  logic [7:0]          cpu_data_i,
    input  logic                cpu_rwb_i,      // High = CPU read
    input  logic                cpu_ack_i,
    input  logic [7:0]          bus_rdata_i,
    output logic                cpu_be_o,
    output logic                cpu_clock_o,    // Phi2
    output logic                cpu_strobe_o,
    output logic [7:0]          cpu_data_o,
    output common_pkg::bus_req_t cpu_req_o
);
    import common_pkg::*;

    logic [CPU_CYCLE_BITS-1:0] cycle_count;
    logic                      rd_pend_q;       // Read was acked last cycle

    // Counter idles at 0 until granted.
    // Once running it always completes the full 16-clock cycle
    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            cycle_count <= CPU_SUSPENDED;
        end else if (cycle_count != CPU_SUSPENDED || cpu_grant_i) begin
            cycle_count <= cycle_count + 1'b1;  // Wraps 15 -> 0
        end
    end

    // Bus outputs decoded from the counter, one clock behind it
    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            cpu_be_o     <= 1'b0;
            cpu_clock_o  <= 1'b0;
            cpu_strobe_o <= 1'b0;
        end else begin
            cpu_strobe_o <= 1'b0;               // Single-cycle pulse
            case (cycle_count)
                CPU_BE_START: begin
                    cpu_be_o <= 1'b1;           // Earlier transfers have drained
                end
                CPU_PHI_START: begin
                    cpu_clock_o  <= 1'b1;       // Address and data setup met
                    cpu_strobe_o <= 1'b1;
                end
                CPU_PHI_END: begin
                    cpu_clock_o <= 1'b0;        // Min Phi2 high width met
                end
                CPU_BE_END: begin
                    cpu_be_o <= 1'b0;           // Hold times met, release the bus
                end
                default: begin
                end
            endcase
        end
    end

    // CPU pins go onto the shared bus only during the strobe cycle
    always_comb begin
        cpu_req_o.valid = cpu_strobe_o;
        cpu_req_o.we    = ~cpu_rwb_i;
        cpu_req_o.addr  = cpu_addr_i;
        cpu_req_o.wdata = cpu_data_i;
    end

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= cpu_ack_i && !cpu_req_o.we;
        end
    end

    // RAM data is on the bus the cycle after the ack
    // and is held here until the next CPU read
    always_ff @(posedge sys_clock_i) begin
        if (rd_pend_q) begin
            cpu_data_o <= bus_rdata_i;
        end
    end

    // The arbiter must serve the CPU on its strobe cycle, never later
    a_cpu_never_delayed : assert property (
        @(posedge sys_clock_i) disable iff (reset_i)
        cpu_req_o.valid |-> cpu_ack_i
    );

    // Phi2 only toggles inside the bus-enable window
    a_phi2_inside_be : assert property (
        @(posedge sys_clock_i) disable iff (reset_i)
        cpu_clock_o |-> cpu_be_o
    );

endmodule

// File: src/common_pkg.sv
// Shared-memory bus types, bus owner encoding and CPU / video timing constants
package common_pkg;

    // RAM geometry
    localparam int RAM_ADDR_BITS = 16;              // 64 KiB of byte RAM
    localparam int DATA_BITS     = 8;               // Byte-wide bus

    // One requester's pending RAM access, held steady until acked
    typedef struct packed {
        logic                     valid;            // Access pending
        logic                     we;               // 1 = write, 0 = read
        logic [RAM_ADDR_BITS-1:0] addr;             // Byte address
        logic [DATA_BITS-1:0]     wdata;            // Write data, ignored on reads
    } bus_req_t;

    // Who owns the RAM port this cycle
    typedef enum logic [1:0] {
        SRC_NONE  = 2'd0,
        SRC_CPU   = 2'd1,
        SRC_VIDEO = 2'd2,
        SRC_HOST  = 2'd3
    } bus_src_e;

    // Screen memory window read by the character fetcher
    localparam logic [RAM_ADDR_BITS-1:0] VIDEO_BASE = 16'h8000;
    localparam int VIDEO_CHARS       = 1000;        // 40 x 25 characters
    localparam int VIDEO_OFFSET_BITS = $clog2(VIDEO_CHARS);

    // CPU cycle counter, 16 system clocks per CPU cycle
    localparam int CPU_CYCLE_BITS = 4;

    // Counter values at which the CPU bus outputs change.
    // BE opens first so in-flight transfers drain, Phi2 rises once
    // setup is met and falls after the minimum high width, and BE
    // closes after the hold times.
    localparam logic [CPU_CYCLE_BITS-1:0] CPU_SUSPENDED = 4'd0;
    localparam logic [CPU_CYCLE_BITS-1:0] CPU_BE_START  = 4'd1;
    localparam logic [CPU_CYCLE_BITS-1:0] CPU_PHI_START = 4'd5;
    localparam logic [CPU_CYCLE_BITS-1:0] CPU_PHI_END   = 4'd9;
    localparam logic [CPU_CYCLE_BITS-1:0] CPU_BE_END    = 4'd13;

endpackage
